// File: source/dsp_seq_pkg.sv
// Shared types, instruction field constants, ureg groups and sequencer register addresses
package dsp_seq_pkg;

	typedef logic [15:0] word_t;
	typedef logic [31:0] instr_t;
	typedef logic [7:0] ureg_addr_t;
	typedef logic [4:0] seq_addr_t;
	typedef logic [3:0] rf_addr_t;

	// Arithmetic status flags, az sits in bit 0
	typedef struct packed {
		logic sz;
		logic sv;
		logic mv;
		logic mn;
		logic ac;
		logic an;
		logic av;
		logic az;
	} status_t;

	typedef enum logic [1:0] {BUS_RF, BUS_DAG, BUS_SEQ, BUS_MEM_IMM} bus_src_t;

	// Single-bit fields of the instruction word
	localparam int COND_BIT = 31;
	localparam int COMPUTE_BIT = 30;
	localparam int DAG_EN_BIT = 29;
	localparam int DAG_SEL_BIT = 28;
	localparam int DM_WR_BIT = 6;

	// Stack opcodes live in bits 29:24, the others in bits 29:26
	localparam logic [5:0] OP_PUSH = 6'd2;
	localparam logic [5:0] OP_POP = 6'd3;
	localparam logic [3:0] OP_IMM = 4'd3;
	localparam logic [3:0] OP_DM = 4'd9;
	localparam logic [3:0] OP_UREG = 4'd1;

	localparam logic [4:0] COND_ALWAYS = 5'd31;

	// Compute unit select in field bits 20:19
	localparam logic [1:0] UNIT_ALU = 2'd0;
	localparam logic [1:0] UNIT_MUL = 2'd1;

	// Ureg groups, upper nibble
	localparam logic [3:0] GRP_RF = 4'h0;
	localparam logic [3:0] GRP_DAG_I = 4'h1;
	localparam logic [3:0] GRP_DAG_M = 4'h2;
	localparam logic [3:0] GRP_SEQ = 4'h6;

	localparam seq_addr_t SEQ_FADDR = 5'd0;
	localparam seq_addr_t SEQ_DADDR = 5'd1;
	localparam seq_addr_t SEQ_PC = 5'd3;
	localparam seq_addr_t SEQ_PCSTK = 5'd4;
	localparam seq_addr_t SEQ_PCSTKP = 5'd5;
	localparam seq_addr_t SEQ_MODE1 = 5'd27;
	localparam seq_addr_t SEQ_ASTAT = 5'd28;
	localparam seq_addr_t SEQ_STKY = 5'd30;

	localparam int STACK_DEPTH = 2;

	// Unit behind a ureg address; sequencer registers span 0x60 to 0x7f
	function automatic bus_src_t ureg_group(ureg_addr_t a);
		if (a[7:4] == GRP_RF)
			return BUS_RF;
		if (a[7:4] == GRP_DAG_I || a[7:4] == GRP_DAG_M)
			return BUS_DAG;
		if (a[7:5] == GRP_SEQ[3:1])
			return BUS_SEQ;
		// Unmapped groups belong to no unit
		return BUS_MEM_IMM;
	endfunction

endpackage

// File: source/cond_decoder.sv
`timescale 1ns/1ps
// Condition code evaluation against the arithmetic status flags
module cond_decoder
	import dsp_seq_pkg::*;
(
	input logic en,
	input logic [4:0] code,
	input status_t status,
	output logic cond_true
);

	logic [7:0] bits;
	logic [2:0] sel;

	assign bits = status;
	assign sel = code[2:0];

	always_comb begin
		if (!en) begin
			// Unconditional instruction
			cond_true = 1'b1;
		end else if (code == COND_ALWAYS) begin
			cond_true = 1'b1;
		end else if (code[4:3] == 2'b00) begin
			// Flag set
			cond_true = bits[sel];
		end else if (code[4:3] == 2'b01) begin
			// Flag clear
			cond_true = !bits[sel];
		end else begin
			cond_true = 1'b0;
		end
	end

endmodule

// File: source/compute_decoder.sv
`timescale 1ns/1ps
// Registered compute field decode into ALU, multiplier and shifter controls
module compute_decoder
	import dsp_seq_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic en,
	input logic [20:0] field,
	output logic alu_en,
	output logic mul_en,
	output logic shf_en,
	output logic alu_logic,
	output logic mul_out_reg,
	output logic [1:0] alu_func,
	output logic [1:0] mul_class,
	output logic [1:0] shf_class,
	output logic [2:0] alu_sel,
	output logic [2:0] cu_wr_en,
	output logic [3:0] mul_fmt,
	output rf_addr_t rf_raddr_x,
	output rf_addr_t rf_raddr_y,
	output rf_addr_t rf_waddr
);

	logic [1:0] unit;
	logic alu_hit;
	logic mul_hit;
	logic shf_hit;

	assign unit = field[20:19];
	assign alu_hit = en && (unit == UNIT_ALU);
	assign mul_hit = en && (unit == UNIT_MUL);
	// Codes 2 and 3 both go to the shifter
	assign shf_hit = en && (unit != UNIT_ALU) && (unit != UNIT_MUL);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			alu_en <= 1'b0;
			mul_en <= 1'b0;
			shf_en <= 1'b0;
			alu_logic <= 1'b0;
			mul_out_reg <= 1'b0;
			alu_func <= '0;
			mul_class <= '0;
			shf_class <= '0;
			alu_sel <= '0;
			cu_wr_en <= '0;
			mul_fmt <= '0;
			rf_raddr_x <= '0;
			rf_raddr_y <= '0;
			rf_waddr <= '0;
		end else begin
			alu_en <= alu_hit;
			mul_en <= mul_hit;
			shf_en <= shf_hit;
			cu_wr_en <= {shf_hit, mul_hit, alu_hit};
			// Function bits are shared, only the selected unit sees them
			alu_func <= alu_hit ? field[18:17] : 2'b00;
			alu_sel <= alu_hit ? field[4:2] : 3'b000;
			alu_logic <= alu_hit && field[1];
			mul_class <= mul_hit ? field[18:17] : 2'b00;
			mul_fmt <= mul_hit ? field[4:1] : 4'b0000;
			mul_out_reg <= mul_hit && field[0];
			shf_class <= shf_hit ? field[18:17] : 2'b00;
			rf_waddr <= en ? field[16:13] : '0;
			rf_raddr_x <= en ? field[12:9] : '0;
			rf_raddr_y <= en ? field[8:5] : '0;
		end
	end

endmodule

// File: source/ureg_decoder.sv
`timescale 1ns/1ps
// Ureg source and destination decode into register-file, DAG and sequencer ports
module ureg_decoder
	import dsp_seq_pkg::*;
(
	input logic push,
	input logic pop,
	input logic imm,
	input logic dm,
	input logic xfer,
	input logic dm_wr,
	input ureg_addr_t ureg1,
	input ureg_addr_t ureg2,
	output logic rf_wr_en,
	output logic dg_wr_en,
	output logic seq_wr_en,
	output rf_addr_t rf_raddr,
	output rf_addr_t rf_waddr,
	output seq_addr_t dg_raddr,
	output seq_addr_t dg_waddr,
	output seq_addr_t seq_raddr,
	output seq_addr_t seq_waddr
);

	ureg_addr_t rd_addr;
	ureg_addr_t wr_addr;
	logic wr_valid;
	bus_src_t wr_grp;

	always_comb begin
		rd_addr = '0;
		wr_addr = '0;
		wr_valid = 1'b0;
		if (xfer) begin
			rd_addr = ureg2;
			wr_addr = ureg1;
			wr_valid = 1'b1;
		end else if (dm && dm_wr) begin
			// Register goes out to data memory
			rd_addr = ureg1;
		end else if (dm || imm) begin
			wr_addr = ureg1;
			wr_valid = 1'b1;
		end else if (push || pop) begin
			rd_addr = {GRP_SEQ[3:1], SEQ_PCSTK};
		end
	end

	assign wr_grp = ureg_group(wr_addr);

	assign rf_wr_en = wr_valid && (wr_grp == BUS_RF);
	assign dg_wr_en = wr_valid && (wr_grp == BUS_DAG);
	assign seq_wr_en = wr_valid && (wr_grp == BUS_SEQ);

	assign rf_raddr = rd_addr[3:0];
	assign rf_waddr = wr_addr[3:0];

	// Index registers at 0..15, modify registers at 16..31
	assign dg_raddr = {rd_addr[5], rd_addr[3:0]};
	assign dg_waddr = {wr_addr[5], wr_addr[3:0]};

	assign seq_raddr = rd_addr[4:0];
	assign seq_waddr = wr_addr[4:0];

endmodule

// File: source/bus_select.sv
`timescale 1ns/1ps
// Bus-connect source and landing selects per instruction class
module bus_select
	import dsp_seq_pkg::*;
(
	input logic push,
	input logic pop,
	input logic imm,
	input logic dm,
	input logic xfer,
	input logic dm_wr,
	input ureg_addr_t ureg1,
	input ureg_addr_t ureg2,
	output bus_src_t dst_sel,
	output bus_src_t din_sel
);

	// dst_sel drives the bus, din_sel is where the word lands
	always_comb begin
		dst_sel = BUS_RF;
		din_sel = BUS_RF;
		if (xfer) begin
			dst_sel = ureg_group(ureg2);
			din_sel = ureg_group(ureg1);
		end else if (dm && dm_wr) begin
			dst_sel = ureg_group(ureg1);
			din_sel = BUS_MEM_IMM;
		end else if (dm || imm) begin
			// Memory read data or immediate field
			dst_sel = BUS_MEM_IMM;
			din_sel = ureg_group(ureg1);
		end else if (push || pop) begin
			dst_sel = BUS_SEQ;
			din_sel = BUS_SEQ;
		end
	end

endmodule

// File: source/seq_status_regs.sv
`timescale 1ns/1ps
// PC stack with sticky status, mode and status registers, read mux and bypass
module seq_status_regs
	import dsp_seq_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic push,
	input logic pop,
	input logic wr_en,
	input logic compute_done,
	input seq_addr_t raddr,
	input seq_addr_t waddr,
	input word_t bc_dt_in,
	input logic [9:0] flags,
	input word_t faddr,
	input word_t daddr,
	input word_t pc,
	output word_t bc_dt
);

	localparam int SP_W = $clog2(STACK_DEPTH + 1);
	localparam int IDX_W = $clog2(STACK_DEPTH);

	word_t stack [STACK_DEPTH];
	logic [SP_W-1:0] sp;
	logic [SP_W-1:0] sp_nxt;
	logic [SP_W-1:0] top;
	logic [2:0] stky;
	logic [2:0] stky_nxt;
	logic push_q;
	logic pop_q;
	logic empty;
	logic full;
	word_t mode1;
	word_t astat;
	word_t live_astat;
	word_t rd_dt;

	// Sticky: bit 0 empty, bit 1 full, bit 2 overflow
	assign empty = stky[0];
	assign full = stky[1];
	assign top = sp - 1'b1;
	assign live_astat = {6'b0, flags};

	// Next pointer and sticky state, also used as the bypass prediction
	always_comb begin
		sp_nxt = sp;
		stky_nxt = stky;
		if (push_q) begin
			stky_nxt[0] = 1'b0;
			if (full) begin
				stky_nxt[2] = 1'b1;
			end else begin
				sp_nxt = sp + 1'b1;
				if (sp == SP_W'(STACK_DEPTH - 1))
					stky_nxt[1] = 1'b1;
			end
		end else if (pop_q && !empty) begin
			sp_nxt = sp - 1'b1;
			stky_nxt[1] = 1'b0;
			if (sp == SP_W'(1))
				stky_nxt[0] = 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			push_q <= 1'b0;
			pop_q <= 1'b0;
			sp <= '0;
			stky <= 3'b001;
			mode1 <= '0;
			astat <= '0;
		end else begin
			push_q <= push;
			pop_q <= pop;
			sp <= sp_nxt;
			stky <= stky_nxt;
			if (wr_en && waddr == SEQ_MODE1)
				mode1 <= bc_dt_in;
			if (wr_en && waddr == SEQ_ASTAT)
				astat <= bc_dt_in;
			else
				astat <= live_astat;
		end
	end

	// Push saves the PC stage address, a ureg write replaces the top
	always_ff @(posedge clk) begin
		if (push_q && !full)
			stack[sp[IDX_W-1:0]] <= pc;
		else if (wr_en && waddr == SEQ_PCSTK && !empty)
			stack[top[IDX_W-1:0]] <= bc_dt_in;
	end

	always_comb begin
		case (raddr)
			SEQ_FADDR: rd_dt = faddr;
			SEQ_DADDR: rd_dt = daddr;
			SEQ_PC: rd_dt = pc;
			SEQ_PCSTK: rd_dt = empty ? '0 : stack[top[IDX_W-1:0]];
			SEQ_PCSTKP: rd_dt = word_t'(sp);
			SEQ_MODE1: rd_dt = mode1;
			SEQ_ASTAT: rd_dt = astat;
			SEQ_STKY: rd_dt = word_t'(stky);
			default: rd_dt = '0;
		endcase
	end

	always_comb begin
		if (wr_en && raddr == waddr)
			bc_dt = bc_dt_in;
		else if (raddr == SEQ_PCSTKP && (push_q || pop_q))
			bc_dt = word_t'(sp_nxt);
		else if (raddr == SEQ_STKY && (push_q || pop_q))
			bc_dt = word_t'(stky_nxt);
		else if (raddr == SEQ_ASTAT && compute_done)
			bc_dt = live_astat;
		else
			bc_dt = rd_dt;
	end

endmodule

// File: source/program_sequencer.sv
`timescale 1ns/1ps
// Program sequencer top with fetch pipeline, instruction classification and decoders
module program_sequencer
	import dsp_seq_pkg::*;
(
	input logic clk,
	input logic rst,
	input instr_t pm_op,
	input logic [9:0] flags,
	input word_t bc_dt_in,
	output word_t pm_add,
	output logic pm_rd,
	output logic dm_cs,
	output logic dm_wr,
	output word_t imm_data,
	output word_t bc_dt,
	output bus_src_t dst_sel,
	output bus_src_t din_sel,
	output logic dg_en,
	output logic dg_sel,
	output logic dg_mdfy,
	output logic [2:0] dg_iadd,
	output logic [2:0] dg_madd,
	output seq_addr_t dg_raddr,
	output seq_addr_t dg_waddr,
	output logic dg_wr_en,
	output rf_addr_t rf_raddr_x,
	output rf_addr_t rf_raddr_y,
	output rf_addr_t rf_waddr,
	output logic rf_wr_en,
	output logic alu_en,
	output logic mul_en,
	output logic shf_en,
	output logic alu_logic,
	output logic mul_out_reg,
	output logic [1:0] alu_func,
	output logic [1:0] mul_class,
	output logic [1:0] shf_class,
	output logic [2:0] alu_sel,
	output logic [2:0] cu_wr_en,
	output logic [3:0] mul_fmt
);

	word_t faddr;
	word_t daddr;
	word_t pc;
	status_t status;
	logic cond_true;
	logic compute_en;
	logic compute_done;
	logic push;
	logic pop;
	logic imm;
	logic dm;
	logic xfer;
	ureg_addr_t ureg1;
	ureg_addr_t ureg2;
	rf_addr_t cd_raddr_x;
	rf_addr_t cd_waddr;
	rf_addr_t ud_rf_raddr;
	rf_addr_t ud_rf_waddr;
	logic seq_wr_en;
	seq_addr_t seq_raddr;
	seq_addr_t seq_waddr;

	// Fetch, decode and PC stages
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			faddr <= '0;
			daddr <= '0;
			pc <= '0;
		end else begin
			faddr <= faddr + 1'b1;
			daddr <= faddr;
			pc <= daddr;
		end
	end

	assign pm_add = faddr;
	// Program memory is read in every cycle out of reset
	assign pm_rd = rst;

	always_ff @(posedge clk) begin
		if (imm)
			imm_data <= pm_op[15:0];
	end

	// as and ss have no condition code
	assign status = {flags[8:5], flags[3:0]};

	cond_decoder i_cond_decoder (
		.en(pm_op[COND_BIT]),
		.code(pm_op[4:0]),
		.status(status),
		.cond_true(cond_true)
	);

	always_comb begin
		push = 1'b0;
		pop = 1'b0;
		imm = 1'b0;
		dm = 1'b0;
		xfer = 1'b0;
		// Nothing decodes while reset holds the fetch
		if (pm_rd && !pm_op[COMPUTE_BIT] && cond_true) begin
			push = (pm_op[29:24] == OP_PUSH);
			pop = (pm_op[29:24] == OP_POP);
			imm = (pm_op[29:26] == OP_IMM);
			dm = (pm_op[29:26] == OP_DM);
			xfer = (pm_op[29:26] == OP_UREG);
		end
	end

	assign compute_en = pm_op[COMPUTE_BIT] && cond_true;
	assign ureg1 = pm_op[23:16];
	assign ureg2 = pm_op[15:8];

	assign dm_cs = dm;
	assign dm_wr = dm && pm_op[DM_WR_BIT];

	assign dg_en = pm_rd && !pm_op[COMPUTE_BIT] && pm_op[DAG_EN_BIT] && cond_true;
	assign dg_sel = pm_op[DAG_SEL_BIT];
	assign dg_mdfy = pm_op[DAG_SEL_BIT];
	assign dg_iadd = pm_op[12:10];
	assign dg_madd = pm_op[9:7];

	compute_decoder i_compute_decoder (
		.clk(clk),
		.rst(rst),
		.en(compute_en),
		.field(pm_op[25:5]),
		.alu_en(alu_en),
		.mul_en(mul_en),
		.shf_en(shf_en),
		.alu_logic(alu_logic),
		.mul_out_reg(mul_out_reg),
		.alu_func(alu_func),
		.mul_class(mul_class),
		.shf_class(shf_class),
		.alu_sel(alu_sel),
		.cu_wr_en(cu_wr_en),
		.mul_fmt(mul_fmt),
		.rf_raddr_x(cd_raddr_x),
		.rf_raddr_y(rf_raddr_y),
		.rf_waddr(cd_waddr)
	);

	// One unit write enable is high in the cycle after a compute opcode
	assign compute_done = |cu_wr_en;
	assign rf_raddr_x = compute_done ? cd_raddr_x : ud_rf_raddr;
	assign rf_waddr = compute_done ? cd_waddr : ud_rf_waddr;

	ureg_decoder i_ureg_decoder (
		.push(push),
		.pop(pop),
		.imm(imm),
		.dm(dm),
		.xfer(xfer),
		.dm_wr(dm_wr),
		.ureg1(ureg1),
		.ureg2(ureg2),
		.rf_wr_en(rf_wr_en),
		.dg_wr_en(dg_wr_en),
		.seq_wr_en(seq_wr_en),
		.rf_raddr(ud_rf_raddr),
		.rf_waddr(ud_rf_waddr),
		.dg_raddr(dg_raddr),
		.dg_waddr(dg_waddr),
		.seq_raddr(seq_raddr),
		.seq_waddr(seq_waddr)
	);

	bus_select i_bus_select (
		.push(push),
		.pop(pop),
		.imm(imm),
		.dm(dm),
		.xfer(xfer),
		.dm_wr(dm_wr),
		.ureg1(ureg1),
		.ureg2(ureg2),
		.dst_sel(dst_sel),
		.din_sel(din_sel)
	);

	seq_status_regs i_seq_status_regs (
		.clk(clk),
		.rst(rst),
		.push(push),
		.pop(pop),
		.wr_en(seq_wr_en),
		.compute_done(compute_done),
		.raddr(seq_raddr),
		.waddr(seq_waddr),
		.bc_dt_in(bc_dt_in),
		.flags(flags),
		.faddr(faddr),
		.daddr(daddr),
		.pc(pc),
		.bc_dt(bc_dt)
	);

endmodule

// File: test/program_sequencer_asserts.sv
// Concurrent checks on the PC stack sticky bits, compute unit enables and dm_cs in reset
`timescale 1ns/1ps
module program_sequencer_asserts (
	input logic clk,
	input logic rst,
	input logic [2:0] stky,
	input logic alu_en,
	input logic mul_en,
	input logic shf_en,
	input logic dm_cs
);

	// Read by the testbench after every vector
	int fail_count = 0;

	// Empty and full exclude each other
	a_stky_excl: assert property (@(posedge clk) disable iff (!rst) !(stky[0] && stky[1]))
	else begin
		fail_count++;
		$error("PC stack sticky shows empty and full together");
	end

	a_one_unit: assert property (@(posedge clk) disable iff (!rst)
		$onehot0({alu_en, mul_en, shf_en}))
	else begin
		fail_count++;
		$error("More than one compute unit enabled");
	end

	a_dm_reset: assert property (@(posedge clk) !rst |-> !dm_cs)
	else begin
		fail_count++;
		$error("dm_cs high during reset");
	end

endmodule

bind program_sequencer program_sequencer_asserts i_asserts (
	.clk(clk),
	.rst(rst),
	.stky(i_seq_status_regs.stky),
	.alu_en(alu_en),
	.mul_en(mul_en),
	.shf_en(shf_en),
	.dm_cs(dm_cs)
);

// File: test/program_sequencer_tb.sv
// Program sequencer testbench with clock, reset, vector playback, compare tasks and watchdog
`timescale 1ns/1ps
module program_sequencer_tb
	import dsp_seq_pkg::*;
();

	localparam int CLK_PERIOD = 100;
	localparam int COLS = 15;
	localparam int VEC_MAX = 64;
	localparam string VEC_FILE = "test/program_sequencer_vectors.txt";
	localparam logic [31:0] SEED = 32'hfd25_edbd;

	// Column positions within one vector line
	localparam int C_OP = 0;
	localparam int C_RAND = 1;
	localparam int C_FLAGS = 2;
	localparam int C_BCIN = 3;
	localparam int C_MASK = 4;
	localparam int C_PMADD = 5;
	localparam int C_DMCS = 6;
	localparam int C_UNITS = 7;
	localparam int C_RFX = 8;
	localparam int C_RFY = 9;
	localparam int C_RFW = 10;
	localparam int C_IMM = 11;
	localparam int C_BC = 12;
	localparam int C_DST = 13;
	localparam int C_DIN = 14;

	logic clk;
	logic rst;
	instr_t pm_op;
	logic [9:0] flags;
	word_t bc_dt_in;
	word_t pm_add;
	logic pm_rd;
	logic dm_cs;
	logic dm_wr;
	word_t imm_data;
	word_t bc_dt;
	bus_src_t dst_sel;
	bus_src_t din_sel;
	logic dg_en;
	logic dg_sel;
	logic dg_mdfy;
	logic [2:0] dg_iadd;
	logic [2:0] dg_madd;
	seq_addr_t dg_raddr;
	seq_addr_t dg_waddr;
	logic dg_wr_en;
	rf_addr_t rf_raddr_x;
	rf_addr_t rf_raddr_y;
	rf_addr_t rf_waddr;
	logic rf_wr_en;
	logic alu_en;
	logic mul_en;
	logic shf_en;
	logic alu_logic;
	logic mul_out_reg;
	logic [1:0] alu_func;
	logic [1:0] mul_class;
	logic [1:0] shf_class;
	logic [2:0] alu_sel;
	logic [2:0] cu_wr_en;
	logic [3:0] mul_fmt;

	logic [31:0] vec_mem [0:VEC_MAX*COLS-1];
	int vec_count = 0;
	// -1 while still in reset
	int vec_idx = -1;

	program_sequencer i_program_sequencer (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic stop_with_failure();
		$display("test failed");
		$fatal(1);
	endtask

	task automatic check_word(input word_t actual, input word_t expected, input string name);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t ns: vector %0d, %s is %h, expected %h",
				$time, vec_idx, name, actual, expected);
			stop_with_failure();
		end
	endtask

	task automatic check_rf(input rf_addr_t actual, input rf_addr_t expected, input string name);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t ns: vector %0d, %s is %h, expected %h",
				$time, vec_idx, name, actual, expected);
			stop_with_failure();
		end
	endtask

	task automatic check_bit(input logic actual, input logic expected, input string name);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t ns: vector %0d, %s is %b, expected %b",
				$time, vec_idx, name, actual, expected);
			stop_with_failure();
		end
	endtask

	task automatic check_src(input bus_src_t actual, input bus_src_t expected, input string name);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t ns: vector %0d, %s is %0d, expected %0d",
				$time, vec_idx, name, actual, expected);
			stop_with_failure();
		end
	endtask

	// Small control codes up to four bits wide
	task automatic check_code(input logic [3:0] actual, input logic [3:0] expected,
		input string name);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t ns: vector %0d, %s is %h, expected %h",
				$time, vec_idx, name, actual, expected);
			stop_with_failure();
		end
	endtask

	function automatic int count_vectors();
		int n;
		n = 0;
		while (n < VEC_MAX && !$isunknown(vec_mem[n*COLS]))
			n++;
		return n;
	endfunction

	task automatic check_reset_state();
		check_bit(alu_en, 1'b0, "alu_en in reset");
		check_bit(mul_en, 1'b0, "mul_en in reset");
		check_bit(shf_en, 1'b0, "shf_en in reset");
		check_bit(dg_en, 1'b0, "dg_en in reset");
		check_bit(dm_cs, 1'b0, "dm_cs in reset");
		check_word(pm_add, 16'h0000, "pm_add in reset");
	endtask

	// Don't-care opcode bits come from $urandom
	task automatic apply_vector(input int n);
		int b;
		b = n * COLS;
		pm_op <= (vec_mem[b+C_OP] & ~vec_mem[b+C_RAND]) | ($urandom() & vec_mem[b+C_RAND]);
		flags <= vec_mem[b+C_FLAGS][9:0];
		bc_dt_in <= vec_mem[b+C_BCIN][15:0];
	endtask

	task automatic check_vector(input int n);
		int b;
		logic [31:0] mask;
		b = n * COLS;
		mask = vec_mem[b+C_MASK];
		if (mask[0])
			check_word(pm_add, vec_mem[b+C_PMADD][15:0], "pm_add");
		if (mask[1])
			check_bit(dm_cs, vec_mem[b+C_DMCS][0], "dm_cs");
		if (mask[2]) begin
			check_bit(alu_en, vec_mem[b+C_UNITS][2], "alu_en");
			check_bit(mul_en, vec_mem[b+C_UNITS][1], "mul_en");
			check_bit(shf_en, vec_mem[b+C_UNITS][0], "shf_en");
		end
		if (mask[3])
			check_rf(rf_raddr_x, vec_mem[b+C_RFX][3:0], "rf_raddr_x");
		if (mask[4])
			check_rf(rf_raddr_y, vec_mem[b+C_RFY][3:0], "rf_raddr_y");
		if (mask[5])
			check_rf(rf_waddr, vec_mem[b+C_RFW][3:0], "rf_waddr");
		if (mask[6])
			check_word(imm_data, vec_mem[b+C_IMM][15:0], "imm_data");
		if (mask[7])
			check_word(bc_dt, vec_mem[b+C_BC][15:0], "bc_dt");
		if (mask[8])
			check_src(dst_sel, bus_src_t'(vec_mem[b+C_DST][1:0]), "dst_sel");
		if (mask[9])
			check_src(din_sel, bus_src_t'(vec_mem[b+C_DIN][1:0]), "din_sel");
	endtask

	// Outputs without a column of their own, judged from the driven opcode
	task automatic check_control_outputs(input int n);
		int b;
		logic [31:0] mask;
		logic exp_dm;
		logic exp_dag;
		bus_src_t exp_din;
		b = n * COLS;
		mask = vec_mem[b+C_MASK];
		exp_dm = vec_mem[b+C_DMCS][0];
		exp_din = bus_src_t'(vec_mem[b+C_DIN][1:0]);
		check_bit(pm_rd, 1'b1, "pm_rd");
		if (mask[1]) begin
			// Every DAG access in the vectors rides on a memory move
			exp_dag = exp_dm && pm_op[DAG_EN_BIT];
			check_bit(dm_wr, exp_dm && pm_op[DM_WR_BIT], "dm_wr");
			check_bit(dg_en, exp_dag, "dg_en");
			if (exp_dag) begin
				check_bit(dg_sel, pm_op[DAG_SEL_BIT], "dg_sel");
				check_bit(dg_mdfy, pm_op[DAG_SEL_BIT], "dg_mdfy");
				check_code(4'(dg_iadd), 4'(pm_op[12:10]), "dg_iadd");
				check_code(4'(dg_madd), 4'(pm_op[9:7]), "dg_madd");
			end
		end
		// No unit enabled means every compute control is cleared
		if (mask[2] && vec_mem[b+C_UNITS][2:0] == 3'b000) begin
			check_bit(alu_logic, 1'b0, "alu_logic");
			check_bit(mul_out_reg, 1'b0, "mul_out_reg");
			check_code(4'(alu_func), 4'h0, "alu_func");
			check_code(4'(mul_class), 4'h0, "mul_class");
			check_code(4'(shf_class), 4'h0, "shf_class");
			check_code(4'(alu_sel), 4'h0, "alu_sel");
			check_code(4'(cu_wr_en), 4'h0, "cu_wr_en");
			check_code(mul_fmt, 4'h0, "mul_fmt");
		end
		// Vectors that check din_sel all carry a ureg write
		if (mask[9]) begin
			check_bit(rf_wr_en, exp_din == BUS_RF, "rf_wr_en");
			check_bit(dg_wr_en, exp_din == BUS_DAG, "dg_wr_en");
		end
	endtask

	task automatic check_assertions();
		if (i_program_sequencer.i_asserts.fail_count != 0) begin
			$display("A bound assertion failed by vector %0d", vec_idx);
			stop_with_failure();
		end
	endtask

	// Two clock periods per vector plus margin for reset
	initial begin
		wait (vec_count > 0);
		#(vec_count * 2 * CLK_PERIOD + 1000);
		$display("Simulation did not finish within the expected time");
		stop_with_failure();
	end

	initial begin
		rst = 1'b0;
		// A memory move with DAG access, held off while in reset
		pm_op = 32'h2402_0000;
		flags = '0;
		bc_dt_in = '0;
		void'($urandom(SEED));
		$readmemh(VEC_FILE, vec_mem);
		vec_count = count_vectors();
		if (vec_count == 0) begin
			$display("No vectors could be read from %s", VEC_FILE);
			stop_with_failure();
		end
		@(posedge clk);
		@(negedge clk);
		check_reset_state();
		@(posedge clk);
		// Reset releases on the same edge that brings the first opcode
		rst <= 1'b1;
		for (vec_idx = 0; vec_idx < vec_count; vec_idx++) begin
			apply_vector(vec_idx);
			#(CLK_PERIOD - 10);
			check_vector(vec_idx);
			check_control_outputs(vec_idx);
			check_assertions();
			@(posedge clk);
		end
		#1;
		if (i_program_sequencer.i_asserts.fail_count != 0) begin
			$display("A bound assertion failed on the last clock edge");
			stop_with_failure();
		end else begin
			$display("test passed");
			$finish;
		end
	end

endmodule

// File: program_sequencer.f
source/dsp_seq_pkg.sv
source/cond_decoder.sv
source/compute_decoder.sv
source/ureg_decoder.sv
source/bus_select.sv
source/seq_status_regs.sv
source/program_sequencer.sv
test/program_sequencer_asserts.sv
test/program_sequencer_tb.sv

// File: test/program_sequencer_vectors.txt
// pm_op rand_mask flags bc_dt_in check_mask | pm_add dm_cs units(alu,mul,shf) rf_x rf_y rf_w
// imm_data bc_dt dst_sel din_sel; mask bits 0 pm_add 1 dm_cs 2 units 3 rf_x 4 rf_y 5 rf_w
// 6 imm_data 7 bc_dt 8 dst_sel 9 din_sel; set bits of rand_mask are filled with random values
00000000 00ffffff 000 0000 007 0000 0 0 0 0 0 0000 0000 0 0 // random no-ops
00000000 00ffffff 000 0000 007 0001 0 0 0 0 0 0000 0000 0 0
00000000 00ffffff 000 0000 007 0002 0 0 0 0 0 0000 0000 0 0
a4020000 0300ffa0 001 0000 003 0003 1 0 0 0 0 0000 0000 0 0 // az set
a4020000 0300ffa0 000 0000 003 0004 0 0 0 0 0 0000 0000 0 0
a4020002 0300ffa0 004 0000 003 0005 1 0 0 0 0 0000 0000 0 0 // an set
a4020004 0300ffa0 020 0000 003 0006 1 0 0 0 0 0000 0000 0 0 // mn set
a4020004 0300ffa0 010 0000 003 0007 0 0 0 0 0 0000 0000 0 0
a4020008 0300ffa0 000 0000 003 0008 1 0 0 0 0 0000 0000 0 0 // not az
a4020008 0300ffa0 001 0000 003 0009 0 0 0 0 0 0000 0000 0 0
a402000f 0300ffa0 100 0000 003 000a 0 0 0 0 0 0000 0000 0 0 // not sz
a402001f 0300ffa0 3ff 0000 003 000b 1 0 0 0 0 0000 0000 0 0 // always
a4020014 0300ffa0 3ff 0000 003 000c 0 0 0 0 0 0000 0000 0 0 // unused code
24020000 0300ffbf 000 0000 003 000d 1 0 0 0 0 0000 0000 0 0 // unconditional
400c4800 3c0003ff 000 0000 007 000e 0 0 0 0 0 0000 0000 0 0 // alu
411d5800 3c0003ff 000 0000 03f 000f 0 4 1 2 3 0000 0000 0 0 // mul
422b3800 3c0003ff 000 0000 03f 0010 0 2 5 6 7 0000 0000 0 0 // shf
c00c4814 3c0003e0 000 0000 03f 0011 0 1 c e a 0000 0000 0 0 // failed condition
04090400 030000ff 000 0000 33f 0012 0 0 4 0 9 0000 0000 0 0 // r9 = r4
047b0300 030000ff 000 5a3c 30f 0013 0 0 3 0 0 0000 0000 0 2 // mode1 = r3
04057b00 030000ff 000 0000 3af 0014 0 0 b 0 5 0000 5a3c 2 0 // r5 = mode1
047b7b00 030000ff 000 c3a5 387 0015 0 0 0 0 0 0000 c3a5 2 2 // bypass
04057b00 030000ff 000 0000 3af 0016 0 0 b 0 5 0000 c3a5 2 0
04007e00 030000ff 000 0000 387 0017 0 0 0 0 0 0000 0001 2 0 // read sticky
02000000 00ffffff 000 0000 007 0018 0 0 0 0 0 0000 0000 0 0 // push
04007e00 030000ff 000 0000 387 0019 0 0 0 0 0 0000 0000 2 0
02000000 00ffffff 000 0000 007 001a 0 0 0 0 0 0000 0000 0 0 // push
04006500 030000ff 000 0000 387 001b 0 0 0 0 0 0000 0002 2 0 // read pointer
04007e00 030000ff 000 0000 387 001c 0 0 0 0 0 0000 0002 2 0 // full
02000000 00ffffff 000 0000 007 001d 0 0 0 0 0 0000 0000 0 0 // push when full
04007e00 030000ff 000 0000 387 001e 0 0 0 0 0 0000 0006 2 0 // overflow
04006500 030000ff 000 0000 387 001f 0 0 0 0 0 0000 0002 2 0
03000000 00ffffff 000 0000 007 0020 0 0 0 0 0 0000 0000 0 0 // pop
04007e00 030000ff 000 0000 387 0021 0 0 0 0 0 0000 0004 2 0
03000000 00ffffff 000 0000 007 0022 0 0 0 0 0 0000 0000 0 0 // pop
04006500 030000ff 000 0000 387 0023 0 0 0 0 0 0000 0000 2 0
03000000 00ffffff 000 0000 007 0024 0 0 0 0 0 0000 0000 0 0 // pop when empty
04007e00 030000ff 000 0000 387 0025 0 0 0 0 0 0000 0005 2 0 // empty again
0c01beef 03000000 000 0000 307 0026 0 0 0 0 0 0000 0000 3 0 // r1 = immediate
00000000 00ffffff 000 0000 047 0027 0 0 0 0 0 beef 0000 0 0
04090400 030000ff 000 0000 047 0028 0 0 0 0 0 beef 0000 0 0
00000000 00ffffff 000 0000 047 0029 0 0 0 0 0 beef 0000 0 0
0c021234 03000000 000 0000 347 002a 0 0 0 0 0 beef 0000 3 0 // r2 = immediate
00000000 00ffffff 000 0000 047 002b 0 0 0 0 0 1234 0000 0 0
